//--- Bender.yml
package:
  name: wb_subsystem

sources:
  - hdl/wb_config_pkg.sv
  - hdl/wb_types_pkg.sv
  - hdl/wb_interfaces.sv
  - hdl/id_tracking.sv
  - hdl/write_back.sv
  - hdl/arch_regfile.sv
  - hdl/wb_subsystem_top.sv
  - target: simulation
    files:
      - sim/wb_tb.sv

//--- hdl/arch_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module arch_regfile (
    input  logic                           clk,
    input  logic                           rst,
    rf_wb_if.rf                            rf_wb,
    input  wb_types_pkg::reg_addr_t        rs_addr,
    output logic [wb_config_pkg::XLEN-1:0] rs_data
);

    // Architectural state
    logic [wb_config_pkg::XLEN-1:0] regs [wb_config_pkg::NUM_REGS-1:0];

    ////////////////////////////////////////////////////////////
    // Write port

    // Commits to x0 carry rd_nzero low and are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < wb_config_pkg::NUM_REGS; r++)
                regs[r] <= '0;
        end else if (rf_wb.commit && rf_wb.rd_nzero) begin
            regs[rf_wb.rd_addr] <= rf_wb.rd_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port

    // x0 hardwired to zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

    // rd_nzero is formed at issue and must agree with the address at commit
    a_nzero_matches_addr: assert property (
        @(posedge clk) disable iff (rst)
        rf_wb.commit |-> !(rf_wb.rd_nzero && (rf_wb.rd_addr == '0))
    ) else $error("arch_regfile: commit flags x0 as a nonzero destination");

endmodule

`default_nettype wire

//--- hdl/id_tracking.sv
`timescale 1ns/10ps
`default_nettype none

module id_tracking (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issued,
    input  logic                          retired,
    output logic                          id_available,
    output wb_types_pkg::instruction_id_t next_id,
    output wb_types_pkg::instruction_id_t oldest_id,
    output logic                          empty
);

    // Allocation and retirement pointers
    wb_types_pkg::instruction_id_t issue_ptr;
    wb_types_pkg::instruction_id_t retire_ptr;
    // Number of IDs in flight
    logic [wb_config_pkg::COUNT_W-1:0] inflight_count;

    ////////////////////////////////////////////////////////////
    // Circular pointers

    // Wrap on their own, ID space is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ptr <= '0;
            retire_ptr <= '0;
        end else begin
            if (issued)
                issue_ptr <= issue_ptr + wb_types_pkg::instruction_id_t'(1);
            if (retired)
                retire_ptr <= retire_ptr + wb_types_pkg::instruction_id_t'(1);
        end
    end

    // Occupancy, unchanged when both strobes coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            case ({issued, retired})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Free ID and oldest ID straight from the pointers
    assign next_id = issue_ptr;
    assign oldest_id = retire_ptr;
    assign empty = (inflight_count == '0);
    assign id_available = (inflight_count !=
        wb_config_pkg::COUNT_W'(wb_config_pkg::MAX_INFLIGHT_COUNT));

    // Write-back only retires something that was issued
    a_no_retire_when_empty: assert property (
        @(posedge clk) disable iff (rst) retired |-> !empty
    ) else $error("id_tracking: retirement with no instruction in flight");

endmodule

`default_nettype wire

//--- hdl/wb_config_pkg.sv
`default_nettype none

package wb_config_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath

    // Result and register width
    localparam int XLEN = 32;

    ////////////////////////////////////////////////////////////
    // Execution units and in-flight window

    // Units reporting results to write-back
    localparam int NUM_WB_UNITS = 2;
    localparam int UNIT_IDX_W = (NUM_WB_UNITS > 1) ? $clog2(NUM_WB_UNITS) : 1;

    // One ID per in-flight instruction, power of two
    localparam int MAX_INFLIGHT_COUNT = 4;
    localparam int ID_W = $clog2(MAX_INFLIGHT_COUNT);
    // Occupancy has to reach the full count
    localparam int COUNT_W = $clog2(MAX_INFLIGHT_COUNT + 1);

    // Architectural register file
    localparam int NUM_REGS = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

endpackage

`default_nettype wire

//--- hdl/wb_interfaces.sv
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////
// Execution unit result report, one instance per unit

interface unit_wb_if;
    // Result valid this cycle
    logic done;
    wb_types_pkg::instruction_id_t id;
    logic [wb_config_pkg::XLEN-1:0] rd;

    modport unit (output done, id, rd);
    modport wb (input done, id, rd);
endinterface

////////////////////////////////////////////////////////////
// Issue side, ID allocation handshake-free

interface tracking_if;
    // Issue strobe, only while an ID is free
    logic issued;
    wb_types_pkg::inflight_packet_t inflight_packet;
    // ID taken by the next issue
    wb_types_pkg::instruction_id_t issue_id;
    logic id_available;

    modport issue (output issued, inflight_packet, input issue_id, id_available);
    modport wb (input issued, inflight_packet, output issue_id, id_available);
endinterface

////////////////////////////////////////////////////////////
// Commit to register file plus one bypass lookup

interface rf_wb_if;
    // Commit group
    logic commit;
    wb_types_pkg::reg_addr_t rd_addr;
    logic rd_nzero;
    wb_types_pkg::instruction_id_t id;
    logic [wb_config_pkg::XLEN-1:0] rd_data;

    // Bypass lookup by ID
    wb_types_pkg::instruction_id_t rs_id;
    logic rs_valid;
    logic [wb_config_pkg::XLEN-1:0] rs_data;

    modport wb (
        output commit, rd_addr, rd_nzero, id, rd_data,
        input  rs_id,
        output rs_valid, rs_data
    );
    modport rf (input commit, rd_addr, rd_nzero, rd_data);
endinterface

`default_nettype wire

//--- hdl/wb_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_subsystem_top (
    input  logic                                clk,
    input  logic                                rst,
    // Issue
    input  logic                                issue,
    input  wb_types_pkg::reg_addr_t             issue_rd_addr,
    input  logic                                issue_is_store,
    output logic                                id_available,
    output wb_types_pkg::instruction_id_t       issue_id,
    // Execution units, one lane per unit
    input  logic [wb_config_pkg::NUM_WB_UNITS-1:0]  unit_done,
    input  wb_types_pkg::instruction_id_t [wb_config_pkg::NUM_WB_UNITS-1:0] unit_id,
    input  logic [wb_config_pkg::NUM_WB_UNITS-1:0][wb_config_pkg::XLEN-1:0] unit_rd,
    // Commit
    output logic                                commit,
    output wb_types_pkg::reg_addr_t             commit_rd_addr,
    output logic [wb_config_pkg::XLEN-1:0]      commit_data,
    output logic                                instruction_complete,
    // Bypass
    input  wb_types_pkg::instruction_id_t       bypass_id,
    output logic                                bypass_valid,
    output logic [wb_config_pkg::XLEN-1:0]      bypass_data,
    // Register read
    input  wb_types_pkg::reg_addr_t             reg_addr,
    output logic [wb_config_pkg::XLEN-1:0]      reg_data,
    output logic                                queue_empty
);

    unit_wb_if  unit_wb [wb_config_pkg::NUM_WB_UNITS-1:0] ();
    tracking_if ti ();
    rf_wb_if    rf_wb ();

    // x0 destination flagged once, at issue
    logic issue_rd_nzero;

    ////////////////////////////////////////////////////////////
    // Port to interface wiring

    for (genvar u = 0; u < wb_config_pkg::NUM_WB_UNITS; u++) begin : g_unit_port
        assign unit_wb[u].done = unit_done[u];
        assign unit_wb[u].id = unit_id[u];
        assign unit_wb[u].rd = unit_rd[u];
    end

    assign issue_rd_nzero = |issue_rd_addr;
    assign ti.issued = issue;
    assign ti.inflight_packet = '{
        rd_addr:  issue_rd_addr,
        rd_nzero: issue_rd_nzero,
        is_store: issue_is_store
    };
    assign id_available = ti.id_available;
    assign issue_id = ti.issue_id;

    // Commit and bypass taken off the register file link
    assign commit = rf_wb.commit;
    assign commit_rd_addr = rf_wb.rd_addr;
    assign commit_data = rf_wb.rd_data;
    assign rf_wb.rs_id = bypass_id;
    assign bypass_valid = rf_wb.rs_valid;
    assign bypass_data = rf_wb.rs_data;

    ////////////////////////////////////////////////////////////
    // Blocks

    write_back u_write_back (
        .clk                  (clk),
        .rst                  (rst),
        .unit_wb              (unit_wb),
        .ti                   (ti),
        .rf_wb                (rf_wb),
        .instruction_complete (instruction_complete),
        .queue_empty          (queue_empty),
        .oldest_id            ()
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .rst     (rst),
        .rf_wb   (rf_wb),
        .rs_addr (reg_addr),
        .rs_data (reg_data)
    );

endmodule

`default_nettype wire

//--- hdl/wb_types_pkg.sv
`default_nettype none

package wb_types_pkg;

    ////////////////////////////////////////////////////////////
    // Identifiers

    // Tag carried from issue to completion
    typedef logic [wb_config_pkg::ID_W-1:0] instruction_id_t;

    // Architectural register index
    typedef logic [wb_config_pkg::REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Issue-time record, kept per ID until retirement

    typedef struct packed {
        reg_addr_t rd_addr;
        // Destination is not x0
        logic      rd_nzero;
        // Stores never reach the register file
        logic      is_store;
    } inflight_packet_t;

endpackage

`default_nettype wire

//--- hdl/write_back.sv
`timescale 1ns/10ps
`default_nettype none

module write_back (
    input  logic                          clk,
    input  logic                          rst,
    unit_wb_if.wb                         unit_wb [wb_config_pkg::NUM_WB_UNITS-1:0],
    tracking_if.wb                        ti,
    rf_wb_if.wb                           rf_wb,
    output logic                          instruction_complete,
    output logic                          queue_empty,
    output wb_types_pkg::instruction_id_t oldest_id
);

    // Unit reports as arrays, indexable in loops
    wb_types_pkg::instruction_id_t unit_id [wb_config_pkg::NUM_WB_UNITS-1:0];
    logic [wb_config_pkg::NUM_WB_UNITS-1:0] unit_done;
    logic [wb_config_pkg::XLEN-1:0] unit_rd [wb_config_pkg::NUM_WB_UNITS-1:0];

    // Result table and the unit feeding each entry
    logic [wb_config_pkg::XLEN-1:0] rds_by_id [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0];
    logic [wb_config_pkg::UNIT_IDX_W-1:0] unit_sel [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0];

    // Done tracking per ID
    logic [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0] id_done_new;
    logic [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0] id_done;
    logic [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0] id_done_r;
    logic [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0] retired_onehot;
    logic [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0] retired_onehot_r;

    // Issue-time packets and the retiring one
    wb_types_pkg::inflight_packet_t packet_table [wb_config_pkg::MAX_INFLIGHT_COUNT-1:0];
    wb_types_pkg::inflight_packet_t retired_packet;
    wb_types_pkg::instruction_id_t retired_id_r;
    logic retired;
    logic retired_r;

    ////////////////////////////////////////////////////////////
    // Result capture

    for (genvar u = 0; u < wb_config_pkg::NUM_WB_UNITS; u++) begin : g_unit_alias
        assign unit_id[u] = unit_wb[u].id;
        assign unit_done[u] = unit_wb[u].done;
        assign unit_rd[u] = unit_wb[u].rd;
    end

    // Match reports against every ID
    always_comb begin
        for (int i = 0; i < wb_config_pkg::MAX_INFLIGHT_COUNT; i++) begin
            id_done_new[i] = 1'b0;
            unit_sel[i] = '0;
            for (int u = 0; u < wb_config_pkg::NUM_WB_UNITS; u++) begin
                if (unit_done[u] && (unit_id[u] == wb_types_pkg::instruction_id_t'(i))) begin
                    id_done_new[i] = 1'b1;
                    unit_sel[i] = wb_config_pkg::UNIT_IDX_W'(u);
                end
            end
        end
    end

    // Payload only, validity lives in the done vector
    always_ff @(posedge clk) begin
        for (int i = 0; i < wb_config_pkg::MAX_INFLIGHT_COUNT; i++) begin
            if (id_done_new[i])
                rds_by_id[i] <= unit_rd[unit_sel[i]];
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue and ordering

    id_tracking u_id_tracking (
        .clk          (clk),
        .rst          (rst),
        .issued       (ti.issued),
        .retired      (retired),
        .id_available (ti.id_available),
        .next_id      (ti.issue_id),
        .oldest_id    (oldest_id),
        .empty        (queue_empty)
    );

    // Destination and store flag kept until retirement
    always_ff @(posedge clk) begin
        if (ti.issued)
            packet_table[ti.issue_id] <= ti.inflight_packet;
    end

    ////////////////////////////////////////////////////////////
    // Retirement

    // Retire the oldest as soon as it is done, same cycle as its report
    assign retired = id_done[oldest_id];

    always_comb begin
        retired_onehot = '0;
        retired_onehot[oldest_id] = retired;
    end

    // Retired bit dropped one cycle after retirement
    assign id_done = (id_done_r & ~retired_onehot_r) | id_done_new;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_done_r <= '0;
            retired_onehot_r <= '0;
            retired_r <= 1'b0;
        end else begin
            id_done_r <= id_done;
            retired_onehot_r <= retired_onehot;
            retired_r <= retired;
        end
    end

    always_ff @(posedge clk) begin
        retired_id_r <= oldest_id;
        retired_packet <= packet_table[oldest_id];
    end

    // Every retirement, stores included
    assign instruction_complete = retired_r;

    // Commit group, one cycle after the retiring edge
    assign rf_wb.commit = retired_r & ~retired_packet.is_store;
    assign rf_wb.rd_addr = retired_packet.rd_addr;
    assign rf_wb.rd_nzero = retired_packet.rd_nzero;
    assign rf_wb.id = retired_id_r;
    assign rf_wb.rd_data = rds_by_id[rf_wb.id];

    // Bypass sees completions up to the last edge
    assign rf_wb.rs_valid = id_done_r[rf_wb.rs_id];
    assign rf_wb.rs_data = rds_by_id[rf_wb.rs_id];

    ////////////////////////////////////////////////////////////
    // Units share the table, so one ID per cycle per unit pair

    for (genvar a = 0; a < wb_config_pkg::NUM_WB_UNITS - 1; a++) begin : g_pair_a
        for (genvar b = a + 1; b < wb_config_pkg::NUM_WB_UNITS; b++) begin : g_pair_b
            a_unique_report_id: assert property (
                @(posedge clk) disable iff (rst)
                !(unit_done[a] && unit_done[b] && (unit_id[a] == unit_id[b]))
            ) else $error("write_back: units %0d and %0d report the same ID", a, b);
        end
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/wb_config_pkg.sv
hdl/wb_types_pkg.sv
hdl/wb_interfaces.sv
hdl/id_tracking.sv
hdl/write_back.sv
hdl/arch_regfile.sv
hdl/wb_subsystem_top.sv
sim/wb_tb.sv

//--- sim/wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module wb_tb;

    localparam int CLK_PERIOD = 100;
    localparam int TABLE_LEN = 10;
    localparam logic [31:0] LFSR_SEED = 32'd32;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // One stimulus row per instruction
    typedef struct {
        wb_types_pkg::reg_addr_t        rd;
        logic                           is_store;
        int                             unit;
        logic [wb_config_pkg::XLEN-1:0] value;
        int                             hold;
    } stim_row_t;

    // Expected retirement, kept in issue order
    typedef struct {
        wb_types_pkg::reg_addr_t        rd;
        logic                           is_store;
        logic [wb_config_pkg::XLEN-1:0] value;
    } expect_t;

    logic clk;
    logic rst;
    logic issue;
    wb_types_pkg::reg_addr_t issue_rd_addr;
    logic issue_is_store;
    logic id_available;
    wb_types_pkg::instruction_id_t issue_id;
    logic [wb_config_pkg::NUM_WB_UNITS-1:0] unit_done;
    wb_types_pkg::instruction_id_t [wb_config_pkg::NUM_WB_UNITS-1:0] unit_id;
    logic [wb_config_pkg::NUM_WB_UNITS-1:0][wb_config_pkg::XLEN-1:0] unit_rd;
    logic commit;
    wb_types_pkg::reg_addr_t commit_rd_addr;
    logic [wb_config_pkg::XLEN-1:0] commit_data;
    logic instruction_complete;
    wb_types_pkg::instruction_id_t bypass_id;
    logic bypass_valid;
    logic [wb_config_pkg::XLEN-1:0] bypass_data;
    wb_types_pkg::reg_addr_t reg_addr;
    logic [wb_config_pkg::XLEN-1:0] reg_data;
    logic queue_empty;

    stim_row_t stim_table [TABLE_LEN];
    wb_types_pkg::instruction_id_t row_id [TABLE_LEN];
    expect_t exp_q [$];
    // Register file model and last known result per ID
    logic [wb_config_pkg::XLEN-1:0] ref_regs [wb_config_pkg::NUM_REGS];
    logic [wb_config_pkg::XLEN-1:0] id_result [wb_config_pkg::MAX_INFLIGHT_COUNT];
    logic id_result_known [wb_config_pkg::MAX_INFLIGHT_COUNT];
    int order [wb_config_pkg::MAX_INFLIGHT_COUNT];
    logic [31:0] lfsr_state;
    int mismatch_count = 0;
    int other_count = 0;
    int retired_count = 0;
    int full_retire_count = 0;
    int bypass_hits = 0;

    wb_subsystem_top u_wb_subsystem_top (
        .clk                  (clk),
        .rst                  (rst),
        .issue                (issue),
        .issue_rd_addr        (issue_rd_addr),
        .issue_is_store       (issue_is_store),
        .id_available         (id_available),
        .issue_id             (issue_id),
        .unit_done            (unit_done),
        .unit_id              (unit_id),
        .unit_rd              (unit_rd),
        .commit               (commit),
        .commit_rd_addr       (commit_rd_addr),
        .commit_data          (commit_data),
        .instruction_complete (instruction_complete),
        .bypass_id            (bypass_id),
        .bypass_valid         (bypass_valid),
        .bypass_data          (bypass_data),
        .reg_addr             (reg_addr),
        .reg_data             (reg_data),
        .queue_empty          (queue_empty)
    );

    ////////////////////////////////////////////////////////////
    // Clock, watchdog, bypass address sweep

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TABLE_LEN * 20 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TABLE_LEN * 20);
        $display("Errors: %0d value, %0d other", mismatch_count, other_count);
        $display("Checks failed");
        $finish;
    end

    // New bypass ID every cycle
    always begin
        @(posedge clk);
        #1;
        bypass_id <= bypass_id + wb_types_pkg::instruction_id_t'(1);
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Lands 1 ns past the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_table();
        // rd, store, unit, result, hold
        stim_table[0] = '{5'd1, 1'b0, 0, 32'h1111_0001, 0};
        stim_table[1] = '{5'd2, 1'b0, 1, 32'h2222_0002, 2};
        // x0 destination that must stay zero
        stim_table[2] = '{5'd0, 1'b0, 0, 32'hdead_0000, 1};
        stim_table[3] = '{5'd3, 1'b1, 1, 32'h5707_0003, 0};
        stim_table[4] = '{5'd1, 1'b0, 1, 32'h1111_0004, 3};
        stim_table[5] = '{5'd4, 1'b0, 0, 32'h4444_0005, 0};
        stim_table[6] = '{5'd5, 1'b1, 0, 32'h5707_0006, 1};
        stim_table[7] = '{5'd2, 1'b0, 1, 32'h2222_0007, 0};
        stim_table[8] = '{5'd31, 1'b0, 0, 32'hffff_0008, 2};
        // Store on x4 leaves the earlier value
        stim_table[9] = '{5'd4, 1'b1, 1, 32'h5707_0009, 1};
    endtask

    // Issue one row
    // IDs are handed out in circular order from zero
    task automatic issue_row(input int row);
        expect_t entry;
        while (!id_available) begin
            issue = 1'b0;
            wait_cycle();
        end
        row_id[row] = wb_types_pkg::instruction_id_t'(
            row % wb_config_pkg::MAX_INFLIGHT_COUNT);
        check_value("issue_id", row_id[row], issue_id);
        issue = 1'b1;
        issue_rd_addr = stim_table[row].rd;
        issue_is_store = stim_table[row].is_store;
        entry.rd = stim_table[row].rd;
        entry.is_store = stim_table[row].is_store;
        entry.value = stim_table[row].value;
        exp_q.push_back(entry);
        wait_cycle();
    endtask

    // Fisher-Yates over the batch slots
    task automatic shuffle_batch(input int count);
        int pick;
        int tmp;
        for (int i = 0; i < count; i++)
            order[i] = i;
        for (int i = count - 1; i > 0; i--) begin
            draw_bits(2, pick);
            pick = pick % (i + 1);
            tmp = order[i];
            order[i] = order[pick];
            order[pick] = tmp;
        end
    endtask

    // Row hold time followed by a one-cycle done pulse
    task automatic complete_row(input int row);
        int u;
        u = stim_table[row].unit;
        repeat (stim_table[row].hold) wait_cycle();
        unit_done[u] = 1'b1;
        unit_id[u] = row_id[row];
        unit_rd[u] = stim_table[row].value;
        id_result[row_id[row]] = stim_table[row].value;
        id_result_known[row_id[row]] = 1'b1;
        wait_cycle();
        unit_done[u] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Retirement and bypass monitor at the falling edge

    always @(negedge clk) begin : monitor
        expect_t head;
        int depth;
        if (!rst) begin
            if (instruction_complete) begin
                depth = exp_q.size();
                if (depth == 0) begin
                    other_count++;
                    $display("Retirement seen with no instruction outstanding");
                end else begin
                    head = exp_q.pop_front();
                    retired_count++;
                    // Window was full before this retirement
                    if (depth == wb_config_pkg::MAX_INFLIGHT_COUNT) begin
                        full_retire_count++;
                        check_value("id_available_after_retire", 1, id_available);
                        check_value("queue_empty_after_retire", 0, queue_empty);
                    end
                    check_value("commit_flag", !head.is_store, commit);
                    if (!head.is_store) begin
                        check_value("commit_rd_addr", head.rd, commit_rd_addr);
                        check_value("commit_data", head.value, commit_data);
                        if (head.rd != '0)
                            ref_regs[head.rd] = head.value;
                    end
                end
            end else if (commit) begin
                other_count++;
                $display("Commit seen without a retirement");
            end
            // Completed results visible by ID
            if (bypass_valid) begin
                if (!id_result_known[bypass_id]) begin
                    other_count++;
                    $display("Bypass valid for ID %0d before any result", bypass_id);
                end else begin
                    bypass_hits++;
                    check_value("bypass_data", id_result[bypass_id], bypass_data);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        int batch_start;
        int batch_len;
        load_table();
        rst = 1'b1;
        issue = 1'b0;
        issue_rd_addr = '0;
        issue_is_store = 1'b0;
        unit_done = '0;
        unit_id = '0;
        unit_rd = '0;
        bypass_id = '0;
        reg_addr = '0;
        lfsr_state = LFSR_SEED;
        for (int r = 0; r < wb_config_pkg::NUM_REGS; r++)
            ref_regs[r] = '0;
        for (int i = 0; i < wb_config_pkg::MAX_INFLIGHT_COUNT; i++) begin
            id_result[i] = '0;
            id_result_known[i] = 1'b0;
        end

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle state out of reset
        @(negedge clk);
        check_value("reset_commit", 0, commit);
        check_value("reset_instruction_complete", 0, instruction_complete);
        check_value("reset_bypass_valid", 0, bypass_valid);
        check_value("reset_queue_empty", 1, queue_empty);
        check_value("reset_id_available", 1, id_available);
        wait_cycle();

        // Batches of up to one full window
        batch_start = 0;
        while (batch_start < TABLE_LEN) begin
            batch_len = TABLE_LEN - batch_start;
            if (batch_len > wb_config_pkg::MAX_INFLIGHT_COUNT)
                batch_len = wb_config_pkg::MAX_INFLIGHT_COUNT;
            for (int k = 0; k < batch_len; k++)
                issue_row(batch_start + k);
            issue = 1'b0;
            if (batch_len == wb_config_pkg::MAX_INFLIGHT_COUNT)
                check_value("id_available_full", 0, id_available);
            shuffle_batch(batch_len);
            for (int k = 0; k < batch_len; k++)
                complete_row(batch_start + order[k]);
            while (exp_q.size() != 0)
                wait_cycle();
            batch_start += batch_len;
        end

        // Drained
        wait_cycle();
        wait_cycle();
        @(negedge clk);
        check_value("drain_commit", 0, commit);
        check_value("drain_queue_empty", 1, queue_empty);
        check_value("retired_count", TABLE_LEN, retired_count);

        // Architectural state against the model
        for (int r = 0; r < wb_config_pkg::NUM_REGS; r++) begin
            wait_cycle();
            reg_addr = wb_types_pkg::reg_addr_t'(r);
            @(negedge clk);
            check_value($sformatf("reg_x%0d", r), ref_regs[r], reg_data);
        end

        if (full_retire_count == 0) begin
            other_count++;
            $display("No retirement happened with the window full");
        end
        if (bypass_hits == 0) begin
            other_count++;
            $display("Bypass never showed a completed result");
        end

        $display("Errors: %0d value, %0d other", mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
